/* dv/box_filter_tb.sv */
module box_filter_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import filter_pkg::*;

  localparam int     IMG_COLS    = 16;
  localparam int     IMG_ROWS    = 12;
  localparam int     N_TESTS     = 6;
  localparam int     TIMEOUT_CYC = 2 * N_TESTS * (IMG_COLS * IMG_ROWS + 20);
  localparam pixel_t CONST_PIX   = 8'hc9;

  typedef enum int {PAT_CONST, PAT_RAMP, PAT_RANDOM, PAT_CHECKER} pattern_e;

  logic     clk;
  logic     rst_n;
  logic     frame_start_i;
  logic     pixel_valid_i;
  pixel_t   pixel_i;
  win_sum_t sum_o;
  logic     sum_valid_o;
  logic     frame_done_o;

  string    test_name  [N_TESTS];
  pattern_e test_pat   [N_TESTS];
  bit       test_gaps  [N_TESTS];
  int       test_count [N_TESTS];

  pixel_t   img [IMG_ROWS][IMG_COLS];
  win_sum_t exp_sum [$];
  int       exp_cyc [$];
  win_sum_t got_sum [$];
  int       got_cyc [$];
  int       cyc      = 0;  // Index of the last clock edge seen.
  int       done_cnt = 0;
  int       errors   = 0;

  box_filter_top #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS)
  ) dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_start_i(frame_start_i),
    .pixel_valid_i(pixel_valid_i),
    .pixel_i      (pixel_i),
    .sum_o        (sum_o),
    .sum_valid_o  (sum_valid_o),
    .frame_done_o (frame_done_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ====================
  // Monitor and timeout
  // ====================
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (sum_valid_o) begin
      got_sum.push_back(sum_o);
      got_cyc.push_back(cyc);  // Edge that registered this sum.
    end
    if (frame_done_o) begin
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (cyc == TIMEOUT_CYC) begin
      $display("Run stopped: no end after %0d cycles, errors so far %0d", cyc, errors);
      $display("Finished with errors");
      $finish;
    end
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic check_sum(input string name, input win_sum_t exp, input win_sum_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // Reference 9x9 sum whose bottom-right corner is (r,c).
  function automatic win_sum_t box_sum(input int r, input int c);
    int acc;
    acc = 0;
    for (int i = r - (KERNEL - 1); i <= r; i++) begin
      for (int j = c - (KERNEL - 1); j <= c; j++) begin
        acc += img[i][j];
      end
    end
    return win_sum_t'(acc);
  endfunction

  task automatic build_image(input pattern_e pat);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        case (pat)
          PAT_CONST:  img[r][c] = CONST_PIX;
          PAT_RAMP:   img[r][c] = pixel_t'(r * IMG_COLS + c);
          PAT_RANDOM: img[r][c] = pixel_t'($urandom);
          default:    img[r][c] = ((r + c) % 2 == 1) ? 8'hf0 : 8'h0f;
        endcase
      end
    end
  endtask

  task automatic stream_frame(input pattern_e pat, input bit gaps);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        if (gaps && ($urandom % 2 == 1)) begin
          pixel_valid_i = 1'b0;  // One idle cycle.
          pixel_i       = '0;
          @(posedge clk);
          #2;
        end
        pixel_valid_i = 1'b1;
        pixel_i       = img[r][c];
        if (r >= KERNEL - 1 && c >= KERNEL - 1) begin
          if (pat == PAT_CONST) begin
            exp_sum.push_back(win_sum_t'(81 * CONST_PIX));
          end else begin
            exp_sum.push_back(box_sum(r, c));
          end
          exp_cyc.push_back(cyc + 1 + 3);  // Accepted at the next edge, summed 3 later.
        end
        @(posedge clk);
        #2;
      end
    end
    pixel_valid_i = 1'b0;
  endtask

  task automatic compare_results(input string name, input int count);
    int n;
    check_count({name, " sum count"}, count, got_sum.size());
    n = (got_sum.size() < exp_sum.size()) ? got_sum.size() : exp_sum.size();
    for (int k = 0; k < n; k++) begin
      check_sum($sformatf("%s sum %0d", name, k), exp_sum[k], got_sum[k]);
      check_count($sformatf("%s sum %0d edge", name, k), exp_cyc[k], got_cyc[k]);
    end
    exp_sum.delete();
    exp_cyc.delete();
    got_sum.delete();
    got_cyc.delete();
  endtask

  // A whole frame of valid pixels without a frame start is ignored.
  task automatic idle_pixels();
    repeat (IMG_COLS * IMG_ROWS) begin
      pixel_valid_i = 1'b1;
      pixel_i       = pixel_t'($urandom);
      @(posedge clk);
      #2;
    end
    pixel_valid_i = 1'b0;
    repeat (6) begin
      @(posedge clk);
      #2;
    end
    check_count("idle_pixels sums", 0, got_sum.size());
    check_count("idle_pixels frame_done pulses", 0, done_cnt);
    got_sum.delete();
    got_cyc.delete();
  endtask

  task automatic run_test(input int idx);
    int start_done;
    int waited;
    start_done = done_cnt;
    waited     = 0;
    build_image(test_pat[idx]);
    frame_start_i = 1'b1;
    @(posedge clk);
    #2;
    frame_start_i = 1'b0;
    stream_frame(test_pat[idx], test_gaps[idx]);
    while (done_cnt == start_done && waited < 10) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (done_cnt == start_done) begin
      $display("%s: frame_done_o did not pulse after the last pixel", test_name[idx]);
      errors++;
    end
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    check_count({test_name[idx], " frame_done pulses"}, 1, done_cnt - start_done);
    compare_results(test_name[idx], test_count[idx]);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    void'($urandom(32'hb0b89398));
    rst_n         = 1'b0;
    frame_start_i = 1'b0;
    pixel_valid_i = 1'b0;
    pixel_i       = '0;

    test_name  = '{"const_frame", "ramp_frame", "random_frame",
                   "ramp_gaps", "random_gaps", "checker_after_random"};
    test_pat   = '{PAT_CONST, PAT_RAMP, PAT_RANDOM, PAT_RAMP, PAT_RANDOM, PAT_CHECKER};
    test_gaps  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    test_count = '{32, 32, 32, 32, 32, 32};  // (16-8) x (12-8) windows.

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    idle_pixels();
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end

    $display("Checks complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* logic/box_filter_top.sv */
module box_filter_top #(
  parameter int IMG_COLS = 64,
  parameter int IMG_ROWS = 48
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 frame_start_i,
  input  logic                 pixel_valid_i,
  input  filter_pkg::pixel_t   pixel_i,
  output filter_pkg::win_sum_t sum_o,
  output logic                 sum_valid_o,
  output logic                 frame_done_o
);
  import filter_pkg::*;

  logic   accept;
  logic   clear;
  logic   win_valid;
  logic   col_valid;
  logic   col_full;
  logic   row_full;
  logic   col_last;
  logic   row_last;
  pixel_t col_pix [KERNEL];
  pixel_t win [KERNEL * KERNEL];

  frame_controller #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_start_i(frame_start_i),
    .pixel_valid_i(pixel_valid_i),
    .col_full_i   (col_full),
    .row_full_i   (row_full),
    .col_last_i   (col_last),
    .row_last_i   (row_last),
    .accept_o     (accept),
    .clear_o      (clear),
    .win_valid_o  (win_valid),
    .frame_done_o (frame_done_o)
  );

  line_buffer_bank #(
    .IMG_COLS(IMG_COLS)
  ) u_lines (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept_i   (accept),
    .pixel_i    (pixel_i),
    .col_pix_o  (col_pix),
    .col_valid_o(col_valid)
  );

  window_buffer_9x9 #(
    .IMG_COLS(IMG_COLS),
    .IMG_ROWS(IMG_ROWS)
  ) u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear),
    .accept_i   (accept),
    .col_valid_i(col_valid),
    .col_pix_i  (col_pix),
    .win_o      (win),
    .col_full_o (col_full),
    .row_full_o (row_full),
    .col_last_o (col_last),
    .row_last_o (row_last)
  );

  window_sum u_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_i      (win),
    .win_valid_i(win_valid),
    .sum_o      (sum_o),
    .sum_valid_o(sum_valid_o)
  );

endmodule

/* logic/filter_pkg.sv */
package filter_pkg;

  // ====================
  // Window geometry
  // ====================
  localparam int KERNEL = 9;  // Edge length of the square window.

  // ====================
  // Data types
  // ====================
  typedef logic [7:0]  pixel_t;    // One greyscale pixel.
  typedef logic [11:0] row_sum_t;  // Holds 9 x 255.
  typedef logic [14:0] win_sum_t;  // Holds 81 x 255.

  typedef enum logic [1:0] {
    IDLE,
    ACTIVE,
    DONE
  } ctrl_state_t;

endpackage

/* logic/frame_controller.sv */
module frame_controller #(
  parameter int IMG_COLS = 64,
  parameter int IMG_ROWS = 48
) (
  input  logic clk,
  input  logic rst_n,
  input  logic frame_start_i,
  input  logic pixel_valid_i,
  input  logic col_full_i,
  input  logic row_full_i,
  input  logic col_last_i,
  input  logic row_last_i,
  output logic accept_o,
  output logic clear_o,
  output logic win_valid_o,
  output logic frame_done_o
);
  import filter_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        hit_q;
  logic        last_pix;

  assign accept_o     = pixel_valid_i && (state_q == ACTIVE);
  assign clear_o      = frame_start_i && (state_q == IDLE);
  assign last_pix     = accept_o && col_last_i && row_last_i;
  assign frame_done_o = (state_q == DONE);

  // ====================
  // Frame FSM
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (frame_start_i) state_d = ACTIVE;
      ACTIVE:  if (last_pix) state_d = DONE;
      DONE:    state_d = IDLE;  // One cycle only.
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows the column into the window one edge later.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_q       <= 1'b0;
      win_valid_o <= 1'b0;
    end else begin
      hit_q       <= accept_o && col_full_i && row_full_i;
      win_valid_o <= hit_q;
    end
  end

endmodule

/* logic/line_buffer_bank.sv */
module line_buffer_bank #(
  parameter int IMG_COLS = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               accept_i,
  input  filter_pkg::pixel_t pixel_i,
  output filter_pkg::pixel_t col_pix_o [filter_pkg::KERNEL],
  output logic               col_valid_o
);
  import filter_pkg::*;

  localparam int LINES = KERNEL - 1;
  localparam int ADDR_W = $clog2(IMG_COLS);
  localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(IMG_COLS - 1);

  logic [ADDR_W-1:0] col_addr;
  pixel_t            rd_pix [LINES];
  pixel_t            wr_pix [LINES];

  // ====================
  // Shared column address
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_addr <= '0;
    end else if (accept_i) begin
      if (col_addr == ADDR_LAST) begin
        col_addr <= '0;  // Wrap at the end of an image line.
      end else begin
        col_addr <= col_addr + 1'b1;
      end
    end
  end

  // ====================
  // Chained row memories
  // ====================
  genvar g;
  generate
    for (g = 0; g < LINES; g++) begin : g_line
      pixel_t row_mem [IMG_COLS];

      assign rd_pix[g] = row_mem[col_addr];  // Pixel g+1 rows above the input.

      if (g == 0) begin : g_head
        assign wr_pix[g] = pixel_i;
      end else begin : g_chain
        assign wr_pix[g] = rd_pix[g-1];  // Old value moves one line further up.
      end

      always_ff @(posedge clk) begin
        if (accept_i) begin
          row_mem[col_addr] <= wr_pix[g];
        end
      end
    end
  endgenerate

  // Column register, oldest row at index 0.
  always_ff @(posedge clk) begin
    if (accept_i) begin
      col_pix_o[KERNEL-1] <= pixel_i;
      for (int k = 0; k < LINES; k++) begin
        col_pix_o[LINES-1-k] <= rd_pix[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
    end else begin
      col_valid_o <= accept_i;
    end
  end

endmodule

/* logic/window_buffer_9x9.sv */
module window_buffer_9x9 #(
  parameter int IMG_COLS = 64,
  parameter int IMG_ROWS = 48
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear_i,
  input  logic               accept_i,
  input  logic               col_valid_i,
  input  filter_pkg::pixel_t col_pix_i [filter_pkg::KERNEL],
  output filter_pkg::pixel_t win_o [filter_pkg::KERNEL * filter_pkg::KERNEL],
  output logic               col_full_o,
  output logic               row_full_o,
  output logic               col_last_o,
  output logic               row_last_o
);
  import filter_pkg::*;

  localparam int COL_W = $clog2(IMG_COLS);
  localparam int ROW_W = $clog2(IMG_ROWS);
  localparam logic [COL_W-1:0] COL_LAST = COL_W'(IMG_COLS - 1);
  localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(IMG_ROWS - 1);
  localparam logic [COL_W-1:0] COL_EDGE = COL_W'(KERNEL - 1);
  localparam logic [ROW_W-1:0] ROW_EDGE = ROW_W'(KERNEL - 1);

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  pixel_t           win_q [KERNEL][KERNEL];

  // ====================
  // Window shift
  // ====================
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int r = 0; r < KERNEL; r++) begin
        for (int c = 0; c < KERNEL - 1; c++) begin
          win_q[r][c] <= win_q[r][c+1];  // Older columns move left.
        end
        win_q[r][KERNEL-1] <= col_pix_i[r];
      end
    end
  end

  genvar gr, gc;
  generate
    for (gr = 0; gr < KERNEL; gr++) begin : g_row
      for (gc = 0; gc < KERNEL; gc++) begin : g_col
        assign win_o[gr*KERNEL + gc] = win_q[gr][gc];
      end
    end
  endgenerate

  // ====================
  // Position counters
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      col_cnt <= '0;
    end else if (accept_i) begin
      if (col_last_o) begin
        col_cnt <= '0;
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      row_cnt <= '0;
    end else if (accept_i && col_last_o) begin
      if (row_last_o) begin
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // The flags describe the pixel being accepted in this cycle.
  assign col_full_o = (col_cnt >= COL_EDGE);
  assign row_full_o = (row_cnt >= ROW_EDGE);
  assign col_last_o = (col_cnt == COL_LAST);
  assign row_last_o = (row_cnt == ROW_LAST);

endmodule

/* logic/window_sum.sv */
module window_sum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  filter_pkg::pixel_t   win_i [filter_pkg::KERNEL * filter_pkg::KERNEL],
  input  logic                 win_valid_i,
  output filter_pkg::win_sum_t sum_o,
  output logic                 sum_valid_o
);
  import filter_pkg::*;

  row_sum_t row_acc [KERNEL];
  row_sum_t row_q   [KERNEL];
  logic     row_valid_q;
  win_sum_t total;

  // ====================
  // Stage one
  // ====================
  always_comb begin
    for (int r = 0; r < KERNEL; r++) begin
      row_acc[r] = '0;
      for (int c = 0; c < KERNEL; c++) begin
        row_acc[r] = row_acc[r] + row_sum_t'(win_i[r*KERNEL + c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < KERNEL; r++) begin
      row_q[r] <= row_acc[r];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_valid_q <= 1'b0;
    end else begin
      row_valid_q <= win_valid_i;
    end
  end

  // ====================
  // Stage two
  // ====================
  always_comb begin
    total = '0;
    for (int r = 0; r < KERNEL; r++) begin
      total = total + win_sum_t'(row_q[r]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_o       <= '0;
      sum_valid_o <= 1'b0;
    end else begin
      sum_o       <= total;        // Runs every cycle, tagged by the valid.
      sum_valid_o <= row_valid_q;
    end
  end

endmodule

/* project.f */
logic/filter_pkg.sv
logic/line_buffer_bank.sv
logic/window_buffer_9x9.sv
logic/window_sum.sv
logic/frame_controller.sv
logic/box_filter_top.sv
dv/box_filter_tb.sv
